// File: rp_cfg.svh
// RP drive register slice
// Build-time configuration

`ifndef RP_CFG_SVH
`define RP_CFG_SVH

//////////////////////////////
// Register bus
//////////////////////////////

// Register data width
`define RP_DATA_W 16

// Register address width
// 32 slots, only three defined
`define RP_ADDR_W 5

//////////////////////////////
// Register map
//////////////////////////////

// Control/status 1
`define RP_ADDR_CS1 0

// Drive status
`define RP_ADDR_DS 1

// Error register 1
`define RP_ADDR_ER1 2

//////////////////////////////
// Timing
//////////////////////////////

// Busy cycles after an accepted function
`define RP_OPTIME 8

`endif

// File: rpPkg.sv
// RP drive shared types

package rpPkg;

   //////////////////////////////
   // Function codes
   //////////////////////////////

   // Legal codes in CS1 bits 5:1
   // Anything not listed is an illegal function
   typedef enum logic [4:0] {
      NOP     = 5'd0,
      UNLOAD  = 5'd1,
      SEEK    = 5'd2,
      RECAL   = 5'd3,
      DRVCLR  = 5'd4,
      RELEASE = 5'd5,
      OFFSET  = 5'd6,
      RETCEN  = 5'd7,
      PRESET  = 5'd8,
      PACKACK = 5'd9,
      SEARCH  = 5'd12,
      WRCHK   = 5'd20,
      WRITE   = 5'd24,
      READ    = 5'd28
   } rpFunc;

   //////////////////////////////
   // Error register 1
   //////////////////////////////

   // MSB first, bit 15 down to bit 0
   typedef struct packed {
      logic dck;   // data check
      logic uns;   // unsafe
      logic opi;   // operation incomplete
      logic dte;   // drive timing error
      logic wle;   // write lock error
      logic iae;   // invalid address
      logic aoe;   // address overflow
      logic hcrc;  // header CRC
      logic hce;   // header compare
      logic ech;   // ECC hard failure
      logic wcf;   // write clock fail
      logic fer;   // format error
      logic par;   // parity
      logic rmr;   // register modification refused
      logic ilr;   // illegal register
      logic ilf;   // illegal function
   } rpEr1T;

   //////////////////////////////
   // Drive status bits
   //////////////////////////////

   // Attention active
   localparam int unsigned DS_ATA = 15;
   // Composite error
   localparam int unsigned DS_ERR = 14;
   // Drive ready
   localparam int unsigned DS_DRY = 7;

endpackage

// File: rpRegIf.sv
// Decoded register access
`timescale 1ns/1ps

`include "rp_cfg.svh"

interface rpRegIf;

   // Write strobes, one per register
   // Each is high for the single write cycle
   logic cs1Write;
   logic dsWrite;
   logic er1Write;

   // Bus write data, shared by all registers
   logic [`RP_DATA_W-1:0] wrData;

   // Read-back values for the mux
   logic [`RP_DATA_W-1:0] cs1Value;
   logic [`RP_DATA_W-1:0] dsValue;

   // Decoder side
   modport decode (
      output cs1Write, dsWrite, er1Write, wrData,
      input  cs1Value, dsValue
   );

   // Register side
   modport register (
      input  cs1Write, dsWrite, er1Write, wrData,
      output cs1Value, dsValue
   );

endinterface

// File: rpErrIf.sv
// Error register control
`timescale 1ns/1ps

interface rpErrIf
   import rpPkg::*;
();

   // From the controller
   logic drvClr;
   logic er1Load;
   logic setIlf;
   logic setRmr;

   // From the decoder
   logic setIlr;

   // Current ER1 contents
   rpEr1T er1Value;

   // Controller side
   modport ctrl (
      output drvClr, er1Load, setIlf, setRmr,
      input  er1Value
   );

   // Decoder needs only ILR and the read-back
   modport decode (
      output setIlr,
      input  er1Value
   );

   // Error register side
   modport er1 (
      input  drvClr, er1Load, setIlf, setRmr, setIlr,
      output er1Value
   );

endinterface

// File: rpRegDecode.sv
// Register address decode and read mux
`timescale 1ns/1ps

`include "rp_cfg.svh"

module rpRegDecode (
   input  logic [`RP_ADDR_W-1:0] addr,
   input  logic                  write,
   input  logic [`RP_DATA_W-1:0] wrData,
   output logic [`RP_DATA_W-1:0] rdData,
   rpRegIf.decode                regs,
   rpErrIf.decode                errs
);

   // Address hits
   logic hitCs1;
   logic hitDs;
   logic hitEr1;
   logic hitAny;

   //////////////////////////////
   // Address compare
   //////////////////////////////

   assign hitCs1 = (addr == `RP_ADDR_W'(`RP_ADDR_CS1));
   assign hitDs  = (addr == `RP_ADDR_W'(`RP_ADDR_DS));
   assign hitEr1 = (addr == `RP_ADDR_W'(`RP_ADDR_ER1));

   // Any defined register
   assign hitAny = hitCs1 | hitDs | hitEr1;

   //////////////////////////////
   // Write strobes
   //////////////////////////////

   // Strobes follow write directly, same cycle
   assign regs.cs1Write = write & hitCs1;
   assign regs.dsWrite  = write & hitDs;
   assign regs.er1Write = write & hitEr1;

   // Data goes to every register, strobe picks one
   assign regs.wrData = wrData;

   // Write to an undefined slot
   // Nothing stored, only the ILR bit
   assign errs.setIlr = write & ~hitAny;

   //////////////////////////////
   // Read mux
   //////////////////////////////

   // Combinational, follows addr
   always_comb
   begin
      if (hitCs1)
         rdData = regs.cs1Value;
      else if (hitDs)
         rdData = regs.dsValue;
      else if (hitEr1)
         rdData = errs.er1Value;
      else
         // Undefined slots read zero
         rdData = '0;
   end

endmodule

// File: rpEr1.sv
// Error register 1
`timescale 1ns/1ps

module rpEr1
   import rpPkg::*;
(
   input  logic      clk,
   input  logic      rstN,
   input  logic      setDck,
   input  logic      setOpi,
   input  logic      setDte,
   input  logic      setWle,
   input  logic      setIae,
   input  logic      setAoe,
   input  logic      setPar,
   input  logic      setHcrc,
   input  logic      hci,
   rpErrIf.er1       errs,
   rpRegIf.register  regs
);

   // Per-bit set requests
   rpEr1T setBits;
   // Software load image
   rpEr1T loadBits;
   // Register contents
   rpEr1T er1Q;

   //////////////////////////////
   // Set sources
   //////////////////////////////

   always_comb
   begin
      setBits = '0;

      // External data path errors
      setBits.dck = setDck;
      setBits.opi = setOpi;
      setBits.dte = setDte;
      setBits.wle = setWle;
      setBits.iae = setIae;
      setBits.aoe = setAoe;
      setBits.par = setPar;

      // Header CRC blocked by header compare inhibit
      setBits.hcrc = setHcrc & ~hci;

      // Internal register access errors
      setBits.rmr = errs.setRmr;
      setBits.ilr = errs.setIlr;
      setBits.ilf = errs.setIlf;

      // UNS, HCE, ECH, WCF and FER have no set source
      // They change only by a load
   end

   // Load image, bit layout matches the bus data
   assign loadBits = rpEr1T'(regs.wrData);

   //////////////////////////////
   // Register
   //////////////////////////////

   // Priority per bit
   //   reset or drive clear
   //   set strobe
   //   load from the bus
   //   hold
   always_ff @(posedge clk)
   begin
      if (!rstN || errs.drvClr)
         er1Q <= '0;
      else if (errs.er1Load)
         // Set bits win over the loaded value
         er1Q <= rpEr1T'(setBits | loadBits);
      else
         er1Q <= rpEr1T'(setBits | er1Q);
   end

   // Read-back and ERR source
   assign errs.er1Value = er1Q;

endmodule

// File: rpCtrl.sv
// Drive control, CS1 and drive status
`timescale 1ns/1ps

`include "rp_cfg.svh"

module rpCtrl
   import rpPkg::*;
(
   input  logic                  clk,
   input  logic                  rstN,
   rpRegIf.register              regs,
   rpErrIf.ctrl                  errs,
   output logic [`RP_DATA_W-1:0] ds
);

   // Counter wide enough for the busy time
   localparam int CntW = $clog2(`RP_OPTIME + 1);

   // Fields of the incoming CS1 write
   logic [4:0]            wrFunc;
   logic                  wrGo;
   logic                  legal;
   // CS1 write taken while ready
   logic                  cs1Ok;
   // Accepted function that keeps the drive busy
   logic                  startOp;
   // Last busy cycle
   logic                  opDone;

   // State
   logic [4:0]            funcQ;
   logic [CntW-1:0]       busyCnt;
   logic                  dry;
   logic                  ata;
   logic [`RP_DATA_W-1:0] dsVal;

   //////////////////////////////
   // Function decode
   //////////////////////////////

   // Function in bits 5:1, GO in bit 0
   assign wrFunc = regs.wrData[5:1];
   assign wrGo   = regs.wrData[0];

   always_comb
   begin
      case (wrFunc)
         NOP, UNLOAD, SEEK, RECAL, DRVCLR, RELEASE, OFFSET, RETCEN,
         PRESET, PACKACK, SEARCH, WRCHK, WRITE, READ:
            legal = 1'b1;
         default:
            legal = 1'b0;
      endcase
   end

   // Writes to CS1 only land while ready
   assign cs1Ok = regs.cs1Write & dry;

   // Drive clear is a one-cycle pulse on the write itself
   assign errs.drvClr = cs1Ok & wrGo & (wrFunc == DRVCLR);
   // Illegal GO, drive stays ready
   assign errs.setIlf = cs1Ok & wrGo & ~legal;
   // Any other legal GO starts the busy period
   assign startOp     = cs1Ok & wrGo & legal & (wrFunc != DRVCLR);

   // ER1 load while ready, otherwise refused
   assign errs.er1Load = regs.er1Write & dry;
   assign errs.setRmr  = (regs.cs1Write | regs.er1Write) & ~dry;

   //////////////////////////////
   // CS1 and busy timer
   //////////////////////////////

   // Stored function code
   always_ff @(posedge clk)
   begin
      if (!rstN)
         funcQ <= NOP;
      else if (cs1Ok)
         funcQ <= wrFunc;
   end

   // Counter reaching zero ends the operation
   assign opDone = ~dry & (busyCnt == '0);

   // DRY low for RP_OPTIME cycles after an accepted GO
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         dry     <= 1'b1;
         busyCnt <= '0;
      end
      else if (startOp)
      begin
         dry     <= 1'b0;
         busyCnt <= CntW'(`RP_OPTIME - 1);
      end
      else if (opDone)
         dry <= 1'b1;
      else if (!dry)
         busyCnt <= busyCnt - 1'b1;
   end

   //////////////////////////////
   // Attention
   //////////////////////////////

   // Completion or illegal function raises ATA
   // A DS write with bit 15 set clears it, unless ATA is raised that same cycle
   always_ff @(posedge clk)
   begin
      if (!rstN || errs.drvClr)
         ata <= 1'b0;
      else if (opDone || errs.setIlf)
         ata <= 1'b1;
      else if (regs.dsWrite && regs.wrData[DS_ATA])
         ata <= 1'b0;
   end

   //////////////////////////////
   // Read-back
   //////////////////////////////

   // GO reads back as set while busy
   assign regs.cs1Value = {{(`RP_DATA_W - 6){1'b0}}, funcQ, ~dry};

   // DS, unlisted bits read zero
   always_comb
   begin
      dsVal         = '0;
      dsVal[DS_ATA] = ata;
      // ERR is the OR of all ER1 bits
      dsVal[DS_ERR] = |errs.er1Value;
      dsVal[DS_DRY] = dry;
   end

   assign regs.dsValue = dsVal;
   assign ds           = dsVal;

endmodule

// File: rpDrive.sv
// RP drive register slice, top level
`timescale 1ns/1ps

`include "rp_cfg.svh"

module rpDrive (
   input  logic                  clk,
   input  logic                  rstN,
   // Register bus
   input  logic [`RP_ADDR_W-1:0] addr,
   input  logic [`RP_DATA_W-1:0] wrData,
   input  logic                  write,
   output logic [`RP_DATA_W-1:0] rdData,
   // Data path error pulses
   input  logic                  setDck,
   input  logic                  setOpi,
   input  logic                  setDte,
   input  logic                  setWle,
   input  logic                  setIae,
   input  logic                  setAoe,
   input  logic                  setPar,
   input  logic                  setHcrc,
   // Header compare inhibit level
   input  logic                  hci,
   // Drive status
   output logic [`RP_DATA_W-1:0] ds
);

   // Internal buses
   rpRegIf regIf ();
   rpErrIf errIf ();

   // Bus decode and read mux
   rpRegDecode uDecode (
      .addr   (addr),
      .write  (write),
      .wrData (wrData),
      .rdData (rdData),
      .regs   (regIf.decode),
      .errs   (errIf.decode)
   );

   // Error register 1
   rpEr1 uEr1 (
      .clk     (clk),
      .rstN    (rstN),
      .setDck  (setDck),
      .setOpi  (setOpi),
      .setDte  (setDte),
      .setWle  (setWle),
      .setIae  (setIae),
      .setAoe  (setAoe),
      .setPar  (setPar),
      .setHcrc (setHcrc),
      .hci     (hci),
      .errs    (errIf.er1),
      .regs    (regIf.register)
   );

   // CS1, busy timer and DS
   rpCtrl uCtrl (
      .clk  (clk),
      .rstN (rstN),
      .regs (regIf.register),
      .errs (errIf.ctrl),
      .ds   (ds)
   );

endmodule

// File: rpClkGen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module rpClkGen #(
   parameter int PeriodNs    = 20,
   parameter int ResetCycles = 10
) (
   output logic clk,
   output logic rstN
);

   // Free-running clock, starts low
   initial
   begin
      clk = 1'b0;
      forever
         #(PeriodNs / 2) clk = ~clk;
   end

   // Reset held low for a fixed number of edges
   initial
   begin
      rstN = 1'b0;
      repeat (ResetCycles) @(posedge clk);
      rstN <= 1'b1;
   end

endmodule

// File: rpTb_asserts.sv
// Drive register slice assertions
`timescale 1ns/1ps

`include "rp_cfg.svh"

module rpTbAsserts
   import rpPkg::*;
(
   input logic                  clk,
   input logic                  rstN,
   input logic [`RP_ADDR_W-1:0] addr,
   input logic [`RP_DATA_W-1:0] wrData,
   input logic                  write,
   input logic [`RP_DATA_W-1:0] rdData,
   input logic [`RP_DATA_W-1:0] ds
);

   // GO with DRVCLR while ready
   logic clearReq;

   assign clearReq = write && (addr == `RP_ADDR_W'(`RP_ADDR_CS1)) && wrData[0]
                     && (wrData[5:1] == 5'd4) && ds[DS_DRY];

   //////////////////////////////
   // Properties
   //////////////////////////////

   // Ready, no attention, no error after any reset edge
   resetState: assert property (@(posedge clk)
      !rstN |=> ds[DS_DRY] && !ds[DS_ATA] && !ds[DS_ERR])
      else $error("drive not idle and ready after reset");

   // Drive clear empties ER1 and ATA, drive stays ready
   clearResult: assert property (@(posedge clk) disable iff (!rstN)
      clearReq |=> !ds[DS_ATA] && !ds[DS_ERR] && ds[DS_DRY])
      else $error("drive clear left ATA, ERR or busy behind");

   // ERR follows the OR of ER1 whenever ER1 is on the read bus
   errTracksEr1: assert property (@(posedge clk) disable iff (!rstN)
      (addr == `RP_ADDR_W'(`RP_ADDR_ER1)) |-> (ds[DS_ERR] == (|rdData)))
      else $error("ERR does not match the OR of ER1");

endmodule

// Attach to every drive instance
bind rpDrive rpTbAsserts uAsserts (
   .clk    (clk),
   .rstN   (rstN),
   .addr   (addr),
   .wrData (wrData),
   .write  (write),
   .rdData (rdData),
   .ds     (ds)
);

// File: rpTb.sv
// RP drive register slice testbench
`timescale 1ns/1ps

`include "rp_cfg.svh"

module rpTb
   import rpPkg::*;
();

   localparam int PeriodNs    = 20;
   localparam int ResetCycles = 10;
   localparam int NumCycles   = 5000;
   // Stimulus length plus reset plus slack
   localparam int TimeoutNs   = (NumCycles + ResetCycles + 50) * PeriodNs;

   // Legal function codes
   localparam logic [4:0] LegalCodes [14] = '{
      5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9,
      5'd12, 5'd20, 5'd24, 5'd28
   };

   logic                  clk;
   logic                  rstN;
   logic [`RP_ADDR_W-1:0] addr;
   logic [`RP_DATA_W-1:0] wrData;
   logic                  write;
   logic [`RP_DATA_W-1:0] rdData;
   logic                  setDck;
   logic                  setOpi;
   logic                  setDte;
   logic                  setWle;
   logic                  setIae;
   logic                  setAoe;
   logic                  setPar;
   logic                  setHcrc;
   logic                  hci;
   logic [`RP_DATA_W-1:0] ds;

   // Reference model state
   logic [4:0]            modelFunc;
   logic                  modelDry;
   logic                  modelAta;
   logic [`RP_DATA_W-1:0] modelEr1;
   int                    busyLeft;

   // Behavior counters
   int nStart;
   int nIllegal;
   int nClear;
   int nRefused;
   int nIlr;
   int nDone;
   int nAtaClr;
   int nHcrcHeld;

   rpClkGen #(.PeriodNs(PeriodNs), .ResetCycles(ResetCycles)) uClk (
      .clk  (clk),
      .rstN (rstN)
   );

   rpDrive DUT (.*);

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic logic isLegalFunc(logic [4:0] code);
      foreach (LegalCodes[i])
         if (LegalCodes[i] == code)
            return 1'b1;
      return 1'b0;
   endfunction

   function automatic logic [`RP_DATA_W-1:0] expectDs();
      logic [`RP_DATA_W-1:0] v;
      v         = '0;
      v[DS_ATA] = modelAta;
      v[DS_ERR] = |modelEr1;
      v[DS_DRY] = modelDry;
      return v;
   endfunction

   function automatic logic [`RP_DATA_W-1:0] expectRead(logic [`RP_ADDR_W-1:0] a);
      if (a == `RP_ADDR_W'(`RP_ADDR_CS1))
         return {{(`RP_DATA_W - 6){1'b0}}, modelFunc, ~modelDry};
      else if (a == `RP_ADDR_W'(`RP_ADDR_DS))
         return expectDs();
      else if (a == `RP_ADDR_W'(`RP_ADDR_ER1))
         return modelEr1;
      // Undefined slots
      return '0;
   endfunction

   // Advance the model by one clock edge on the sampled inputs
   task automatic modelEdge();
      rpEr1T sets;
      logic  isCs1;
      logic  isDs;
      logic  isEr1;
      logic  go;
      logic  clear;
      logic  badFunc;
      logic  start;
      logic  done;
      logic [4:0] code;
      isCs1 = write && (addr == `RP_ADDR_W'(`RP_ADDR_CS1));
      isDs  = write && (addr == `RP_ADDR_W'(`RP_ADDR_DS));
      isEr1 = write && (addr == `RP_ADDR_W'(`RP_ADDR_ER1));
      code  = wrData[5:1];
      go    = wrData[0];

      // Error sources for this edge
      sets      = '0;
      sets.dck  = setDck;
      sets.opi  = setOpi;
      sets.dte  = setDte;
      sets.wle  = setWle;
      sets.iae  = setIae;
      sets.aoe  = setAoe;
      sets.par  = setPar;
      sets.hcrc = setHcrc && !hci;
      sets.rmr  = (isCs1 || isEr1) && !modelDry;
      sets.ilr  = write && !isCs1 && !isDs && !isEr1;

      clear    = isCs1 && modelDry && go && (code == 5'd4);
      badFunc  = isCs1 && modelDry && go && !isLegalFunc(code);
      start    = isCs1 && modelDry && go && isLegalFunc(code) && (code != 5'd4);
      sets.ilf = badFunc;
      done     = 1'b0;

      // Drive clear beats sets, sets beat the load
      if (clear)
         modelEr1 = '0;
      else if (isEr1 && modelDry)
         modelEr1 = wrData | sets;
      else
         modelEr1 = modelEr1 | sets;

      if (isCs1 && modelDry)
         modelFunc = code;

      // Busy period
      if (start)
      begin
         modelDry = 1'b0;
         busyLeft = `RP_OPTIME;
      end
      else if (!modelDry)
      begin
         busyLeft--;
         if (busyLeft == 0)
         begin
            modelDry = 1'b1;
            done     = 1'b1;
         end
      end

      // Raising ATA wins over a DS clear in the same edge
      if (clear)
         modelAta = 1'b0;
      else if (done || badFunc)
         modelAta = 1'b1;
      else if (isDs && wrData[DS_ATA])
      begin
         if (modelAta)
            nAtaClr++;
         modelAta = 1'b0;
      end

      nStart    += int'(start);
      nIllegal  += int'(badFunc);
      nClear    += int'(clear);
      nRefused  += int'(sets.rmr);
      nIlr      += int'(sets.ilr);
      nDone     += int'(done);
      nHcrcHeld += int'(setHcrc && hci);
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   function automatic logic [`RP_ADDR_W-1:0] pickAddr();
      int r;
      r = $urandom_range(0, 3);
      case (r)
         0:       return `RP_ADDR_W'(`RP_ADDR_CS1);
         1:       return `RP_ADDR_W'(`RP_ADDR_DS);
         2:       return `RP_ADDR_W'(`RP_ADDR_ER1);
         default: return `RP_ADDR_W'($urandom_range(3, (1 << `RP_ADDR_W) - 1));
      endcase
   endfunction

   // CS1 word biased toward drive clear and illegal codes
   function automatic logic [`RP_DATA_W-1:0] cs1Word();
      int         r;
      logic [4:0] code;
      logic       go;
      r = $urandom_range(0, 7);
      if (r < 2)
         code = 5'd4;
      else if (r < 4)
         code = 5'($urandom);
      else
         code = LegalCodes[$urandom_range(0, 13)];
      go = ($urandom_range(0, 3) != 0);
      // Random upper bits that must not matter
      return {10'($urandom), code, go};
   endfunction

   task automatic driveCycle();
      int                    action;
      int                    pick;
      logic [`RP_ADDR_W-1:0] a;
      action = $urandom_range(0, 3);
      a      = pickAddr();
      // Default is a plain read with no strobes
      addr    <= a;
      write   <= 1'b0;
      wrData  <= 16'($urandom);
      setDck  <= 1'b0;
      setOpi  <= 1'b0;
      setDte  <= 1'b0;
      setWle  <= 1'b0;
      setIae  <= 1'b0;
      setAoe  <= 1'b0;
      setPar  <= 1'b0;
      setHcrc <= 1'b0;
      case (action)
         0:
         begin
            write <= ($urandom_range(0, 3) != 0);
            if (a == `RP_ADDR_W'(`RP_ADDR_CS1))
               wrData <= cs1Word();
            else if (a == `RP_ADDR_W'(`RP_ADDR_ER1) && $urandom_range(0, 1) == 0)
               wrData <= '0;
         end
         1:
         begin
            pick = $urandom_range(0, 7);
            case (pick)
               0:       setDck  <= 1'b1;
               1:       setOpi  <= 1'b1;
               2:       setDte  <= 1'b1;
               3:       setWle  <= 1'b1;
               4:       setIae  <= 1'b1;
               5:       setAoe  <= 1'b1;
               6:       setPar  <= 1'b1;
               default: setHcrc <= 1'b1;
            endcase
         end
         2:       hci <= 1'($urandom_range(0, 1));
         default: ;
      endcase
   endtask

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic checkValue(input string what, input logic [`RP_DATA_W-1:0] actual,
                             input logic [`RP_DATA_W-1:0] expected);
      if (actual !== expected)
      begin
         $display("ERROR %0d ns: %s mismatch, got %h expected %h",
                  $time, what, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "%s mismatch", what);
      end
   endtask

   task automatic requireSeen(input string what, input int count);
      if (count == 0)
      begin
         $display("Stimulus never produced: %s", what);
         $display("TEST FAILED");
         $fatal(1, "missing stimulus: %s", what);
      end
   endtask

   // Watchdog
   initial
   begin
      #(TimeoutNs);
      $display("Watchdog expired after %0d ns, the stimulus loop did not finish", TimeoutNs);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

   initial
   begin
      void'($urandom(32'h9d89aa2d));
      nStart    = 0;
      nIllegal  = 0;
      nClear    = 0;
      nRefused  = 0;
      nIlr      = 0;
      nDone     = 0;
      nAtaClr   = 0;
      nHcrcHeld = 0;
      addr      = '0;
      wrData    = '0;
      write     = 1'b0;
      setDck    = 1'b0;
      setOpi    = 1'b0;
      setDte    = 1'b0;
      setWle    = 1'b0;
      setIae    = 1'b0;
      setAoe    = 1'b0;
      setPar    = 1'b0;
      setHcrc   = 1'b0;
      hci       = 1'b0;
      // Model comes out of reset ready and clean
      modelFunc = '0;
      modelDry  = 1'b1;
      modelAta  = 1'b0;
      modelEr1  = '0;
      busyLeft  = 0;

      wait (rstN === 1'b1);
      for (int cycle = 0; cycle < NumCycles; cycle++)
      begin
         @(posedge clk);
         modelEdge();
         driveCycle();
         // State and new inputs settle by mid-cycle
         @(negedge clk);
         checkValue("ds", ds, expectDs());
         checkValue("rdData", rdData, expectRead(addr));
      end

      requireSeen("accepted GO", nStart);
      requireSeen("completed busy period", nDone);
      requireSeen("illegal GO", nIllegal);
      requireSeen("drive clear", nClear);
      requireSeen("refused write", nRefused);
      requireSeen("undefined register write", nIlr);
      requireSeen("ATA cleared by DS write", nAtaClr);
      requireSeen("HCRC held off by hci", nHcrcHeld);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: list.f
+incdir+.
rpPkg.sv
rpRegIf.sv
rpErrIf.sv
rpRegDecode.sv
rpEr1.sv
rpCtrl.sv
rpDrive.sv
rpClkGen.sv
rpTb_asserts.sv
rpTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RP drive testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rpTb -f list.f -o rpTbSim
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
   echo "Verilator build failed with status $buildStatus"
   exit 1
fi

./obj_dir/rpTbSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "TEST FAILED" "$logFile"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ "$runStatus" -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi

exit 0
